// File: common/rv_decode_settings.svh
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

// ------------------------------------------------------------------------
// Widths
// ------------------------------------------------------------------------

`define RV_XLEN   32   // Data and address width
`define RV_REG_AW 5    // Register address width
`define RV_UOP_W  5    // Micro-op width

// ------------------------------------------------------------------------
// Reset value and trap causes
// ------------------------------------------------------------------------

`define RV_PC_RESET     32'h8000_0000
`define RV_TRAP_IACCESS 5'd1   // Fetch error
`define RV_TRAP_IOPCODE 5'd2   // Invalid encoding

`endif

// File: common/rv_decode_pkg.sv
`include "rv_decode_settings.svh"

package rv_decode_pkg;

    // --------------------------------------------------------------------
    // Instruction word, seen in each base format
    // --------------------------------------------------------------------

    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_word_u;

    // --------------------------------------------------------------------
    // Unit select and micro-op codes
    // --------------------------------------------------------------------

    typedef struct packed {
        logic alu;
        logic cfu;
        logic lsu;
    } fu_t;

    typedef enum logic [`RV_UOP_W-1:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
    } alu_op_e;

    typedef enum logic [`RV_UOP_W-1:0] {
        cfu_beq, cfu_bne, cfu_blt, cfu_bge,
        cfu_bltu, cfu_bgeu, cfu_jali, cfu_jalr
    } cfu_op_e;

    typedef enum logic [1:0] {
        lsu_byte, lsu_half, lsu_word
    } lsu_width_e;

    typedef struct packed {
        logic       load;
        logic       store;
        lsu_width_e width;
        logic       sign;   // Sign extend the loaded value
    } lsu_op_t;

    typedef struct packed {
        logic a_rs1;
        logic a_pcim;
        logic b_rs2;
        logic b_imm;
        logic c_rs2;
        logic c_pcim;
    } opr_src_t;

    // --------------------------------------------------------------------
    // Stage payloads
    // --------------------------------------------------------------------

    typedef struct packed {
        fu_t                  fu;
        logic [`RV_UOP_W-1:0] uop;
        opr_src_t             src;
        logic                 invalid;
    } class_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] imm;      // Operand immediate
        logic [`RV_XLEN-1:0] imm_pc;   // Added to the PC
    } imm_t;

    typedef struct packed {
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   opr_a;
        logic [`RV_XLEN-1:0]   opr_b;
        logic [`RV_XLEN-1:0]   opr_c;
        logic [`RV_UOP_W-1:0]  uop;
        fu_t                   fu;
        logic                  trap;
    } stage_t;

endpackage

// File: decode/instr_classify.sv
`include "rv_decode_settings.svh"

module instr_classify import rv_decode_pkg::*; (
    input  instr_word_u data,   // Fetched word
    output class_t      cls
);

    logic                 ok;
    fu_t                  fu;
    logic [`RV_UOP_W-1:0] uop;
    opr_src_t             src;
    lsu_op_t              lop;
    logic [2:0]           f3;
    logic [6:0]           f7;

    assign f3 = data.r.funct3;
    assign f7 = data.r.funct7;   // Upper immediate bits on OP-IMM

    // Shared by OP and OP-IMM where alt picks sub or sra
    function automatic alu_op_e alu_decode(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    // ------------------------------------------------------------------------
    // Opcode match
    // ------------------------------------------------------------------------

    always_comb begin
        ok  = 1'b0;
        fu  = '0;
        uop = '0;
        src = '0;
        lop = '0;
        case (data.r.opcode)
            opc_lui: begin
                ok         = 1'b1;
                fu.alu     = 1'b1;
                uop        = alu_or;   // Zero OR immediate
                src.b_imm  = 1'b1;
            end
            opc_auipc: begin
                ok         = 1'b1;
                fu.alu     = 1'b1;
                uop        = alu_add;
                src.a_pcim = 1'b1;
            end
            opc_jal: begin
                ok         = 1'b1;
                fu.cfu     = 1'b1;
                uop        = cfu_jali;
                src.c_pcim = 1'b1;     // Jump target
            end
            opc_jalr: begin
                ok         = (f3 == 3'b000);
                fu.cfu     = 1'b1;
                uop        = cfu_jalr;
                src.a_rs1  = 1'b1;
                src.b_imm  = 1'b1;
            end
            opc_branch: begin
                ok         = (f3[2:1] != 2'b01);   // 010 and 011 unused
                fu.cfu     = 1'b1;
                case (f3)
                    3'b000:  uop = cfu_beq;
                    3'b001:  uop = cfu_bne;
                    3'b100:  uop = cfu_blt;
                    3'b101:  uop = cfu_bge;
                    3'b110:  uop = cfu_bltu;
                    default: uop = cfu_bgeu;
                endcase
                src.a_rs1  = 1'b1;
                src.b_rs2  = 1'b1;
                src.c_pcim = 1'b1;
            end
            opc_load: begin
                ok         = (f3 != 3'b011) && (f3[2:1] != 2'b11);
                fu.lsu     = 1'b1;
                lop.load   = 1'b1;
                lop.width  = lsu_width_e'(f3[1:0]);
                lop.sign   = !f3[2] && (f3[1:0] != 2'b10);   // lb, lh
                uop        = lop;
                src.a_rs1  = 1'b1;
                src.b_imm  = 1'b1;
            end
            opc_store: begin
                ok         = !f3[2] && (f3 != 3'b011);
                fu.lsu     = 1'b1;
                lop.store  = 1'b1;
                lop.width  = lsu_width_e'(f3[1:0]);
                uop        = lop;
                src.a_rs1  = 1'b1;
                src.b_imm  = 1'b1;
                src.c_rs2  = 1'b1;     // Store data
            end
            opc_op_imm: begin
                case (f3)
                    3'b001:  ok = (f7 == 7'b0000000);
                    3'b101:  ok = (f7 == 7'b0000000) || (f7 == 7'b0100000);
                    default: ok = 1'b1;
                endcase
                fu.alu     = 1'b1;
                uop        = alu_decode(f3, (f3 == 3'b101) && f7[5]);
                src.a_rs1  = 1'b1;
                src.b_imm  = 1'b1;
            end
            opc_op: begin
                ok         = (f7 == 7'b0000000) ||
                             ((f7 == 7'b0100000) && (f3 == 3'b000 || f3 == 3'b101));
                fu.alu     = 1'b1;
                uop        = alu_decode(f3, f7[5]);
                src.a_rs1  = 1'b1;
                src.b_rs2  = 1'b1;
            end
            default: ok = 1'b0;        // Compressed, system, fence, CSR
        endcase

        cls         = '0;
        cls.invalid = !ok;
        if (ok) begin
            cls.fu  = fu;
            cls.uop = uop;
            cls.src = src;
        end
    end

endmodule

// File: decode/imm_extract.sv
`include "rv_decode_settings.svh"

module imm_extract import rv_decode_pkg::*; (
    input  instr_word_u data,
    output imm_t        imm
);

    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    logic [`RV_XLEN-1:0] imm_sh;
    logic                shift;

    assign imm_i  = {{20{data.i.imm[11]}}, data.i.imm};
    assign imm_s  = {{20{data.s.imm_hi[6]}}, data.s.imm_hi, data.s.imm_lo};
    assign imm_b  = {{19{data.b.imm_12}}, data.b.imm_12, data.b.imm_11,
                     data.b.imm_10_5, data.b.imm_4_1, 1'b0};
    assign imm_u  = {data.u.imm, 12'b0};
    assign imm_j  = {{11{data.j.imm_20}}, data.j.imm_20, data.j.imm_19_12,
                     data.j.imm_11, data.j.imm_10_1, 1'b0};
    assign imm_sh = {27'b0, data.r.rs2};                // Shamt only
    assign shift  = (data.i.funct3[1:0] == 2'b01);      // slli, srli, srai

    always_comb begin
        imm = '0;
        case (data.r.opcode)
            opc_lui, opc_auipc: begin
                imm.imm    = imm_u;
                imm.imm_pc = imm_u;
            end
            opc_jal: begin
                imm.imm    = imm_j;
                imm.imm_pc = imm_j;
            end
            opc_branch: begin
                imm.imm    = imm_b;
                imm.imm_pc = imm_b;
            end
            opc_jalr, opc_load: imm.imm = imm_i;
            opc_store:          imm.imm = imm_s;
            opc_op_imm:         imm.imm = shift ? imm_sh : imm_i;
            default:            imm     = '0;
        endcase
    end

endmodule

// File: hdl/pc_track.sv
`include "rv_decode_settings.svh"

module pc_track (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  logic                advance,       // Word accepted this cycle
    input  logic                cf_req,
    input  logic                cf_ack,
    input  logic [`RV_XLEN-1:0] cf_target,
    input  logic [`RV_XLEN-1:0] imm_pc,
    output logic [`RV_XLEN-1:0] pc_plus_imm
);

    logic [`RV_XLEN-1:0] pc;

    // ------------------------------------------------------------------------
    // Program counter
    // ------------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= `RV_PC_RESET;
        end else if (cf_req && cf_ack) begin
            pc <= cf_target;                  // Redirect wins
        end else if (advance) begin
            pc <= pc + `RV_XLEN'd4;           // All kept instructions are 4 bytes
        end
    end

    // Branch and jump targets, AUIPC result
    assign pc_plus_imm = pc + imm_pc;

endmodule

// File: hdl/operand_assemble.sv
`include "rv_decode_settings.svh"

module operand_assemble import rv_decode_pkg::*; (
    input  class_t                cls,
    input  imm_t                  imm,
    input  logic [`RV_XLEN-1:0]   rs1_rdata,
    input  logic [`RV_XLEN-1:0]   rs2_rdata,
    input  logic [`RV_XLEN-1:0]   pc_plus_imm,
    input  logic [`RV_REG_AW-1:0] rd_field,
    input  logic                  fetch_error,
    output stage_t                entry
);

    lsu_op_t lop;
    logic    trap;
    logic    no_rd;

    assign lop   = cls.uop;
    assign trap  = cls.invalid || fetch_error;
    assign no_rd = (cls.fu.lsu && lop.store) ||
                   (cls.fu.cfu && cls.uop != cfu_jali && cls.uop != cfu_jalr);

    // ------------------------------------------------------------------------
    // Operand selection
    // ------------------------------------------------------------------------

    assign entry.opr_a = {`RV_XLEN{cls.src.a_rs1}}  & rs1_rdata |
                         {`RV_XLEN{cls.src.a_pcim}} & pc_plus_imm;

    assign entry.opr_b = {`RV_XLEN{cls.src.b_rs2}}  & rs2_rdata |
                         {`RV_XLEN{cls.src.b_imm}}  & imm.imm;

    assign entry.opr_c = {`RV_XLEN{cls.src.c_rs2}}  & rs2_rdata |
                         {`RV_XLEN{cls.src.c_pcim}} & pc_plus_imm;

    // ------------------------------------------------------------------------
    // Destination and trap
    // ------------------------------------------------------------------------

    always_comb begin
        if (trap) begin
            // Invalid encoding beats a fetch error
            entry.rd = cls.invalid ? `RV_TRAP_IOPCODE : `RV_TRAP_IACCESS;
        end else if (no_rd) begin
            entry.rd = '0;                 // Stores and branches
        end else begin
            entry.rd = rd_field;
        end
    end

    assign entry.uop  = cls.uop;
    assign entry.fu   = cls.fu;
    assign entry.trap = trap;

endmodule

// File: hdl/stage_register.sv
module stage_register import rv_decode_pkg::*; (
    input  logic   g_clk,
    input  logic   g_resetn,
    input  logic   valid_in,
    input  stage_t entry_in,
    input  logic   bubble,
    input  logic   flush,
    output logic   busy_in,
    output logic   valid_out,
    output stage_t entry_out,
    input  logic   busy_out
);

    logic   stall;
    stage_t bubble_entry;

    assign stall   = valid_out && busy_out;   // Held entry not taken
    assign busy_in = stall || bubble;

    // Operands pass through and everything else is cleared
    always_comb begin
        bubble_entry      = entry_in;
        bubble_entry.rd   = '0;
        bubble_entry.uop  = '0;
        bubble_entry.fu   = '0;
        bubble_entry.trap = 1'b0;
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            valid_out <= 1'b0;
        end else if (flush) begin
            valid_out <= 1'b0;
        end else if (!stall) begin
            valid_out <= valid_in || bubble;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!stall && (valid_in || bubble)) begin
            entry_out <= bubble ? bubble_entry : entry_in;
        end
    end

endmodule

// File: decode/rv_decode_stage.sv
`include "rv_decode_settings.svh"

module rv_decode_stage import rv_decode_pkg::*; (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  s1_valid,
    output logic                  s1_busy,
    input  logic [`RV_XLEN-1:0]   s1_data,
    input  logic                  s1_error,     // Fetch error on s1_data
    input  logic                  s1_flush,
    input  logic                  s1_bubble,
    output logic [`RV_REG_AW-1:0] s1_rs1_addr,
    output logic [`RV_REG_AW-1:0] s1_rs2_addr,
    input  logic [`RV_XLEN-1:0]   s1_rs1_rdata,
    input  logic [`RV_XLEN-1:0]   s1_rs2_rdata,
    input  logic                  cf_req,
    input  logic [`RV_XLEN-1:0]   cf_target,
    input  logic                  cf_ack,
    output logic                  s2_valid,
    input  logic                  s2_busy,
    output stage_t                s2_entry
);

    instr_word_u         word;
    class_t              cls;
    imm_t                imm;
    logic [`RV_XLEN-1:0] pc_plus_imm;
    stage_t              entry;
    logic                advance;

    assign word        = s1_data;
    assign s1_rs1_addr = word.r.rs1;
    assign s1_rs2_addr = word.r.rs2;
    assign advance     = s1_valid && !s1_busy;   // Word accepted

    instr_classify i_classify (
        .data (word),
        .cls  (cls)
    );

    imm_extract i_imm (
        .data (word),
        .imm  (imm)
    );

    pc_track i_pc (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .advance     (advance),
        .cf_req      (cf_req),
        .cf_ack      (cf_ack),
        .cf_target   (cf_target),
        .imm_pc      (imm.imm_pc),
        .pc_plus_imm (pc_plus_imm)
    );

    operand_assemble i_operands (
        .cls         (cls),
        .imm         (imm),
        .rs1_rdata   (s1_rs1_rdata),
        .rs2_rdata   (s1_rs2_rdata),
        .pc_plus_imm (pc_plus_imm),
        .rd_field    (word.r.rd),
        .fetch_error (s1_error),
        .entry       (entry)
    );

    stage_register i_s2_reg (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .valid_in  (s1_valid),
        .entry_in  (entry),
        .bubble    (s1_bubble),
        .flush     (s1_flush),
        .busy_in   (s1_busy),
        .valid_out (s2_valid),
        .entry_out (s2_entry),
        .busy_out  (s2_busy)
    );

endmodule

// File: bench/rv_decode_tb.sv
`include "rv_decode_settings.svh"

module rv_decode_tb import rv_decode_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_TESTS        = 6;
    localparam int WORDS          = 250;                     // Drive cycles per test
    localparam int CLK_NS         = 4;
    localparam int TIMEOUT_CYCLES = N_TESTS * WORDS * 8;

    logic                  g_clk, g_resetn;
    logic                  s1_valid, s1_busy, s1_error, s1_flush, s1_bubble;
    logic [`RV_XLEN-1:0]   s1_data, s1_rs1_rdata, s1_rs2_rdata, cf_target;
    logic [`RV_REG_AW-1:0] s1_rs1_addr, s1_rs2_addr;
    logic                  cf_req, cf_ack, s2_valid, s2_busy;
    stage_t                s2_entry;

    integer                seed = 32'hebb9_b4e3;
    logic [`RV_XLEN-1:0]   m_pc;                             // Model PC
    logic                  m_valid;                          // Model s2_valid
    stage_t                exp_q[$];                         // Expected s2 entries
    string                 cur_test;
    int                    errors, accepted, tests_failed;

    rv_decode_stage i_dut (.*);

    always #(CLK_NS / 2) g_clk = ~g_clk;

    // Register file stand-in with a same cycle read
    function automatic logic [31:0] reg_value(input logic [4:0] a);
        return ({27'd0, a} * 32'h0123_4567) ^ {a, 27'd0} ^ 32'h5a5a_3c3c;
    endfunction
    assign s1_rs1_rdata = reg_value(s1_rs1_addr);
    assign s1_rs2_rdata = reg_value(s1_rs2_addr);

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // ------------------------------------------------------------------------
    // Reference decoder
    // ------------------------------------------------------------------------

    function automatic stage_t model_entry(input logic [31:0] w, input logic err,
                                           input logic [31:0] pc);
        stage_t      e;
        lsu_op_t     lop;
        logic        ok, link;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] rs1v, rs2v, i_imm, s_imm, b_imm, u_imm, j_imm, shamt;
        f3    = w[14:12];
        f7    = w[31:25];
        rs1v  = reg_value(w[19:15]);
        rs2v  = reg_value(w[24:20]);
        i_imm = {{20{w[31]}}, w[31:20]};
        s_imm = {{20{w[31]}}, w[31:25], w[11:7]};
        b_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        u_imm = {w[31:12], 12'h000};
        j_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        shamt = {27'd0, w[24:20]};
        e     = '0;
        lop   = '0;
        ok    = 1'b1;
        link  = 1'b1;                                        // Writes rd
        case (w[6:0])
            7'b0110111: begin                                // LUI
                e.fu.alu = 1'b1;
                e.uop    = alu_or;
                e.opr_b  = u_imm;
            end
            7'b0010111: begin                                // AUIPC
                e.fu.alu = 1'b1;
                e.uop    = alu_add;
                e.opr_a  = pc + u_imm;
            end
            7'b1101111: begin                                // JAL
                e.fu.cfu = 1'b1;
                e.uop    = cfu_jali;
                e.opr_c  = pc + j_imm;
            end
            7'b1100111: begin                                // JALR
                ok       = (f3 == 3'd0);
                e.fu.cfu = 1'b1;
                e.uop    = cfu_jalr;
                e.opr_a  = rs1v;
                e.opr_b  = i_imm;
            end
            7'b1100011: begin                                // Branches
                link     = 1'b0;
                e.fu.cfu = 1'b1;
                e.opr_a  = rs1v;
                e.opr_b  = rs2v;
                e.opr_c  = pc + b_imm;
                case (f3)
                    3'd0:    e.uop = cfu_beq;
                    3'd1:    e.uop = cfu_bne;
                    3'd4:    e.uop = cfu_blt;
                    3'd5:    e.uop = cfu_bge;
                    3'd6:    e.uop = cfu_bltu;
                    3'd7:    e.uop = cfu_bgeu;
                    default: ok = 1'b0;
                endcase
            end
            7'b0000011: begin                                // Loads
                ok = (f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd2) || (f3 == 3'd4) ||
                     (f3 == 3'd5);
                lop.load  = 1'b1;
                lop.width = lsu_width_e'(f3[1:0]);
                lop.sign  = (f3 == 3'd0) || (f3 == 3'd1);
                e.fu.lsu  = 1'b1;
                e.uop     = lop;
                e.opr_a   = rs1v;
                e.opr_b   = i_imm;
            end
            7'b0100011: begin                                // Stores
                ok        = (f3 <= 3'd2);
                link      = 1'b0;
                lop.store = 1'b1;
                lop.width = lsu_width_e'(f3[1:0]);
                e.fu.lsu  = 1'b1;
                e.uop     = lop;
                e.opr_a   = rs1v;
                e.opr_b   = s_imm;
                e.opr_c   = rs2v;
            end
            7'b0010011: begin                                // OP-IMM
                e.fu.alu = 1'b1;
                e.opr_a  = rs1v;
                e.opr_b  = i_imm;
                case (f3)
                    3'd0: e.uop = alu_add;
                    3'd2: e.uop = alu_slt;
                    3'd3: e.uop = alu_sltu;
                    3'd4: e.uop = alu_xor;
                    3'd6: e.uop = alu_or;
                    3'd7: e.uop = alu_and;
                    3'd1: begin
                        e.uop   = alu_sll;
                        e.opr_b = shamt;
                        ok      = (f7 == 7'h00);
                    end
                    default: begin
                        e.uop   = (f7 == 7'h20) ? alu_sra : alu_srl;
                        e.opr_b = shamt;
                        ok      = (f7 == 7'h00) || (f7 == 7'h20);
                    end
                endcase
            end
            7'b0110011: begin                                // OP
                e.fu.alu = 1'b1;
                e.opr_a  = rs1v;
                e.opr_b  = rs2v;
                if (f7 == 7'h20 && f3 == 3'd0) e.uop = alu_sub;
                else if (f7 == 7'h20 && f3 == 3'd5) e.uop = alu_sra;
                else if (f7 != 7'h00) ok = 1'b0;
                else begin
                    case (f3)
                        3'd0: e.uop = alu_add;
                        3'd1: e.uop = alu_sll;
                        3'd2: e.uop = alu_slt;
                        3'd3: e.uop = alu_sltu;
                        3'd4: e.uop = alu_xor;
                        3'd5: e.uop = alu_srl;
                        3'd6: e.uop = alu_or;
                        default: e.uop = alu_and;
                    endcase
                end
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            e      = '0;
            e.trap = 1'b1;
            e.rd   = `RV_TRAP_IOPCODE;
        end else if (err) begin
            e.trap = 1'b1;
            e.rd   = `RV_TRAP_IACCESS;
        end else if (link) begin
            e.rd = w[11:7];
        end
        return e;
    endfunction

    // ------------------------------------------------------------------------
    // Word generators
    // ------------------------------------------------------------------------

    function automatic logic [31:0] make_word(input int kind);
        logic [31:0] w, r;
        logic [2:0]  lf3 [5];
        logic [2:0]  bf3 [6];
        lf3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        bf3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        w = rand32();
        r = rand32();
        case (kind)
            0: begin                                         // ALU forms
                case (r[1:0])
                    2'd0: w[6:0] = 7'b0110111;
                    2'd3: begin
                        w[6:0]   = 7'b0110011;
                        w[31:25] = (r[2] && (w[13:12] == 2'b01 || w[14:12] == 3'd0) &&
                                    w[14:12] != 3'd1) ? 7'h20 : 7'h00;
                    end
                    default: begin
                        w[6:0] = 7'b0010011;
                        if (w[14:12] == 3'd1) w[31:25] = 7'h00;
                        if (w[14:12] == 3'd5) w[31:25] = r[2] ? 7'h20 : 7'h00;
                    end
                endcase
            end
            1: begin                                         // Loads and stores
                if (r[0]) begin
                    w[6:0]   = 7'b0000011;
                    w[14:12] = lf3[r[10:3] % 5];
                end else begin
                    w[6:0]   = 7'b0100011;
                    w[14:12] = r[10:3] % 3;
                end
            end
            2: begin                                         // Control flow, AUIPC
                case (r[1:0])
                    2'd0: begin
                        w[6:0]   = 7'b1100011;
                        w[14:12] = bf3[r[10:3] % 6];
                    end
                    2'd1: w[6:0] = 7'b1101111;
                    2'd2: begin
                        w[6:0]   = 7'b1100111;
                        w[14:12] = 3'd0;
                    end
                    default: w[6:0] = 7'b0010111;
                endcase
            end
            default: begin                                   // Bad encodings
                case (r[1:0])
                    2'd0: w[1:0] = (r[3:2] == 2'b11) ? 2'b00 : r[3:2];  // Compressed
                    2'd1: w[6:0] = r[2] ? 7'b1110011 : 7'b0001111;      // System, fence
                    2'd2: begin
                        w[6:0]   = 7'b0110011;
                        w[31:25] = 7'h01;                    // M extension
                    end
                    default: w = rand32();
                endcase
            end
        endcase
        return w;
    endfunction

    // ------------------------------------------------------------------------
    // Check and predict one cycle
    // ------------------------------------------------------------------------

    task automatic report_mismatch(input string what, input logic [127:0] exp,
                                   input logic [127:0] act);
        errors++;
        $display("Fail %s: %s expected %0h actual %0h", cur_test, what, exp, act);
    endtask

    task automatic step();
        logic   stall, busy_exp, accept, load;
        stage_t exp_e;
        #1;                                                  // Mid low phase
        stall    = m_valid && s2_busy;
        busy_exp = stall || s1_bubble;
        accept   = s1_valid && !busy_exp;
        load     = !stall && (s1_valid || s1_bubble);
        if (s1_busy !== busy_exp) report_mismatch("s1_busy", busy_exp, s1_busy);
        if (s1_rs1_addr !== s1_data[19:15])
            report_mismatch("rs1_addr", s1_data[19:15], s1_rs1_addr);
        if (s1_rs2_addr !== s1_data[24:20])
            report_mismatch("rs2_addr", s1_data[24:20], s1_rs2_addr);
        if (s2_valid !== m_valid) report_mismatch("s2_valid", m_valid, s2_valid);
        if (m_valid && s2_entry !== exp_q[0])
            report_mismatch("s2_entry", exp_q[0], s2_entry);
        exp_e = model_entry(s1_data, s1_error, m_pc);
        if (s1_bubble) begin
            exp_e.rd   = '0;
            exp_e.uop  = '0;
            exp_e.fu   = '0;
            exp_e.trap = 1'b0;
        end
        @(posedge g_clk);
        if (m_valid && !s2_busy) void'(exp_q.pop_front());   // Taken downstream
        if (s1_flush) begin
            exp_q.delete();
            m_valid = 1'b0;
        end else if (!stall) begin
            if (load) exp_q.push_back(exp_e);
            m_valid = load;
        end
        if (cf_req && cf_ack) m_pc = cf_target;
        else if (accept) m_pc = m_pc + 32'd4;
        if (accept) accepted++;
        @(negedge g_clk);
    endtask

    task automatic idle_inputs();
        s1_valid  = 1'b0;
        s1_error  = 1'b0;
        s1_flush  = 1'b0;
        s1_bubble = 1'b0;
        cf_req    = 1'b0;
        cf_ack    = 1'b0;
        s2_busy   = 1'b0;
    endtask

    task automatic run_test(input int kind, input string name);
        int          i, err0, acc0;
        logic [31:0] r;
        cur_test = name;
        err0     = errors;
        acc0     = accepted;
        for (i = 0; i < WORDS; i++) begin
            idle_inputs();
            r        = rand32();
            s1_valid = 1'b1;
            s1_data  = make_word(kind < 4 ? kind : r[9:8]);
            case (kind)
                2: begin
                    cf_req    = (r[2:0] == 3'd0);
                    cf_ack    = r[3];
                    cf_target = rand32() & 32'hffff_fffc;
                end
                3: begin
                    s1_data  = r[4] ? make_word(3) : make_word(r[6:5]);
                    s1_error = (r[12:11] == 2'd0);
                end
                4: begin
                    s1_valid = (r[1:0] != 2'd0);
                    s2_busy  = r[2];
                end
                5: begin
                    s1_valid  = r[0];
                    s2_busy   = (r[3:2] == 2'd0);
                    s1_flush  = (r[7:4] < 4'd2);
                    s1_bubble = (r[11:8] < 4'd3);
                end
                default: ;
            endcase
            step();
        end
        idle_inputs();
        while (m_valid) step();                              // Drain the s2 register
        if (errors != err0) tests_failed++;
        $display("Test %s %s: %0d words accepted, %0d errors", name,
                 (errors == err0) ? "ok" : "failed", accepted - acc0, errors - err0);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------

    initial begin
        g_clk     = 1'b0;
        g_resetn  = 1'b0;
        s1_data   = '0;
        cf_target = '0;
        idle_inputs();
        m_pc      = `RV_PC_RESET;
        m_valid   = 1'b0;
        cur_test  = "reset";
        repeat (16) @(posedge g_clk);
        @(negedge g_clk);
        if (s2_valid !== 1'b0) report_mismatch("s2_valid", 1'b0, s2_valid);
        if (s1_busy !== 1'b0) report_mismatch("s1_busy", 1'b0, s1_busy);
        g_resetn = 1'b1;
        run_test(0, "alu");
        run_test(1, "load_store");
        run_test(2, "control");
        run_test(3, "traps");
        run_test(4, "backpressure");
        run_test(5, "flush_bubble");
        $display("Summary: %0d tests, %0d failed, %0d words accepted, %0d errors",
                 N_TESTS, tests_failed, accepted, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_NS);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: rv_decode.f
+incdir+common
common/rv_decode_pkg.sv
decode/instr_classify.sv
decode/imm_extract.sv
hdl/pc_track.sv
hdl/operand_assemble.sv
hdl/stage_register.sv
decode/rv_decode_stage.sv
bench/rv_decode_tb.sv

// File: Bender.yml
package:
  name: rv_decode

export_include_dirs:
  - common

sources:
  - files:
      - common/rv_decode_pkg.sv
      - decode/instr_classify.sv
      - decode/imm_extract.sv
      - hdl/pc_track.sv
      - hdl/operand_assemble.sv
      - hdl/stage_register.sv
      - decode/rv_decode_stage.sv

  - target: test
    files:
      - bench/rv_decode_tb.sv
